// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_simd_alu
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard test/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/alu_compare.sv
// SIMD comparator
// byte compares chained into lane results, compare mask and min/max select
`timescale 1ns/1ps
`default_nettype none

module alu_compare (
  input  alu_data_pkg::simd_word_u           operand_a_i,
  input  alu_data_pkg::simd_word_u           operand_b_i,
  alu_ctrl_if.cmp                            ctrl,
  output logic [alu_data_pkg::NUM_BYTES-1:0] cmp_lanes_o,
  output alu_data_pkg::simd_word_u           minmax_o
);

  // byte-level building blocks
  logic [alu_data_pkg::NUM_BYTES-1:0] eq_b;
  logic [alu_data_pkg::NUM_BYTES-1:0] gt_b;
  // per byte, replicated across each lane
  logic [alu_data_pkg::NUM_BYTES-1:0] is_eq;
  logic [alu_data_pkg::NUM_BYTES-1:0] is_gt;
  logic [alu_data_pkg::NUM_BYTES-1:0] sel_a;

  // signed compare only where the byte holds a lane sign bit
  always_comb begin
    for (int i = 0; i < alu_data_pkg::NUM_BYTES; i++) begin
      eq_b[i] = (operand_a_i.b[i] == operand_b_i.b[i]);
      gt_b[i] = $signed({ctrl.cmp_signed[i] & operand_a_i.b[i][alu_data_pkg::BYTE_W-1],
                         operand_a_i.b[i]}) >
                $signed({ctrl.cmp_signed[i] & operand_b_i.b[i][alu_data_pkg::BYTE_W-1],
                         operand_b_i.b[i]});
    end
  end

  // upper byte decides, lower byte only breaks a tie
  always_comb begin
    case (ctrl.vec_mode)
      alu_op_pkg::VEC_MODE8: begin
        is_eq = eq_b;
        is_gt = gt_b;
      end
      alu_op_pkg::VEC_MODE16: begin
        for (int j = 0; j < 2; j++) begin
          is_eq[2*j +: 2] = {2{eq_b[2*j+1] & eq_b[2*j]}};
          is_gt[2*j +: 2] = {2{gt_b[2*j+1] | (eq_b[2*j+1] & gt_b[2*j])}};
        end
      end
      default: begin
        is_eq = {4{&eq_b}};
        is_gt = {4{gt_b[3] | (eq_b[3] & (gt_b[2] | (eq_b[2] &
                   (gt_b[1] | (eq_b[1] & gt_b[0])))))}};
      end
    endcase
  end

  always_comb begin
    case (ctrl.cmp_op)
      alu_op_pkg::CMP_NE: cmp_lanes_o = ~is_eq;
      alu_op_pkg::CMP_LT: cmp_lanes_o = ~(is_gt | is_eq);
      alu_op_pkg::CMP_GE: cmp_lanes_o = is_gt | is_eq;
      default:            cmp_lanes_o = is_eq;
    endcase
  end

  // max keeps a when a > b, min keeps a when a <= b
  assign sel_a = is_gt ^ {alu_data_pkg::NUM_BYTES{ctrl.do_min}};

  always_comb begin
    for (int i = 0; i < alu_data_pkg::NUM_BYTES; i++) begin
      minmax_o.b[i] = sel_a[i] ? operand_a_i.b[i] : operand_b_i.b[i];
    end
  end

  // lane mask must agree with the lane split seen by the top-level mux
  always_comb begin
    assert final ($isunknown(cmp_lanes_o) ||
                  (ctrl.vec_mode != alu_op_pkg::VEC_MODE16) ||
                  ((cmp_lanes_o[1] == cmp_lanes_o[0]) &&
                   (cmp_lanes_o[3] == cmp_lanes_o[2])))
      else $error("compare mask split inside a 16-bit lane");
    assert final ($isunknown(cmp_lanes_o) ||
                  (ctrl.vec_mode != alu_op_pkg::VEC_MODE32) ||
                  (cmp_lanes_o == '0) || (cmp_lanes_o == '1))
      else $error("compare mask not uniform in 32-bit mode");
  end

endmodule

`default_nettype wire

// File: hdl/alu_ctrl_if.sv
// ALU control bundle
// carries decoded operation control from the decoder to the lane datapaths
`timescale 1ns/1ps
`default_nettype none

interface alu_ctrl_if;

  alu_op_pkg::vec_mode_e              vec_mode;
  // adder
  logic                               sub;
  // shifter
  logic                               shift_left;
  logic                               shift_arith;
  // compare, one signed bit per byte lane
  logic [alu_data_pkg::NUM_BYTES-1:0] cmp_signed;
  alu_op_pkg::cmp_op_e                cmp_op;
  logic                               do_min;
  // result mux
  alu_op_pkg::logic_op_e              logic_op;
  alu_op_pkg::res_sel_e               res_sel;

  modport dec (
    output vec_mode, sub, shift_left, shift_arith,
    output cmp_signed, cmp_op, do_min, logic_op, res_sel
  );
  modport add   (input vec_mode, sub);
  modport shift (input vec_mode, shift_left, shift_arith);
  modport cmp   (input vec_mode, cmp_signed, cmp_op, do_min);
  modport res   (input res_sel, logic_op);

endinterface

`default_nettype wire

// File: hdl/alu_data_pkg.sv
// SIMD ALU data definitions
// word width, byte lane geometry and the two-way SIMD word view
`default_nettype none

package alu_data_pkg;

  // word and lane widths
  localparam int XLEN      = 32;
  localparam int NUM_BYTES = 4;
  localparam int BYTE_W    = 8;
  localparam int HALF_W    = 16;
  // shift amount for a full 32-bit lane
  localparam int SHAMT_W   = 5;
  // one adder segment is a separator bit plus a byte
  localparam int ADD_SEG_W = BYTE_W + 1;

  // one operand word, read as four bytes or as two halfwords
  // depending on the vector mode
  typedef union packed {
    logic [NUM_BYTES-1:0][BYTE_W-1:0] b;
    logic [1:0][HALF_W-1:0]           h;
  } simd_word_u;

endpackage

`default_nettype wire

// File: hdl/alu_decoder.sv
// ALU operator decoder
// turns operator and vector mode into control for adder, shifter and compare
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
  input  alu_op_pkg::alu_op_e   operator_i,
  input  alu_op_pkg::vec_mode_e vec_mode_i,
  alu_ctrl_if.dec               ctrl
);

  logic is_signed;

  always_comb begin
    // defaults give an unsigned equality compare and the adder result
    is_signed        = 1'b0;
    ctrl.vec_mode    = vec_mode_i;
    ctrl.sub         = 1'b0;
    ctrl.shift_left  = 1'b0;
    ctrl.shift_arith = 1'b0;
    ctrl.cmp_op      = alu_op_pkg::CMP_EQ;
    ctrl.do_min      = 1'b0;
    ctrl.logic_op    = alu_op_pkg::LOGIC_AND;
    ctrl.res_sel     = alu_op_pkg::RES_ADD;

    case (operator_i)
      alu_op_pkg::ALU_SUB: ctrl.sub = 1'b1;
      alu_op_pkg::ALU_AND: ctrl.res_sel = alu_op_pkg::RES_LOGIC;
      alu_op_pkg::ALU_OR: begin
        ctrl.res_sel  = alu_op_pkg::RES_LOGIC;
        ctrl.logic_op = alu_op_pkg::LOGIC_OR;
      end
      alu_op_pkg::ALU_XOR: begin
        ctrl.res_sel  = alu_op_pkg::RES_LOGIC;
        ctrl.logic_op = alu_op_pkg::LOGIC_XOR;
      end
      // shifts
      alu_op_pkg::ALU_SLL: begin
        ctrl.res_sel    = alu_op_pkg::RES_SHIFT;
        ctrl.shift_left = 1'b1;
      end
      alu_op_pkg::ALU_SRL: ctrl.res_sel = alu_op_pkg::RES_SHIFT;
      alu_op_pkg::ALU_SRA: begin
        ctrl.res_sel     = alu_op_pkg::RES_SHIFT;
        ctrl.shift_arith = 1'b1;
      end
      // vector compares
      alu_op_pkg::ALU_EQ: ctrl.res_sel = alu_op_pkg::RES_VCMP;
      alu_op_pkg::ALU_NE: begin
        ctrl.res_sel = alu_op_pkg::RES_VCMP;
        ctrl.cmp_op  = alu_op_pkg::CMP_NE;
      end
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LTU: begin
        is_signed    = (operator_i == alu_op_pkg::ALU_LTS);
        ctrl.res_sel = alu_op_pkg::RES_VCMP;
        ctrl.cmp_op  = alu_op_pkg::CMP_LT;
      end
      alu_op_pkg::ALU_GES, alu_op_pkg::ALU_GEU: begin
        is_signed    = (operator_i == alu_op_pkg::ALU_GES);
        ctrl.res_sel = alu_op_pkg::RES_VCMP;
        ctrl.cmp_op  = alu_op_pkg::CMP_GE;
      end
      // set-less-than, result taken from the top lane
      alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_SLTU: begin
        is_signed    = (operator_i == alu_op_pkg::ALU_SLTS);
        ctrl.res_sel = alu_op_pkg::RES_SLT;
        ctrl.cmp_op  = alu_op_pkg::CMP_LT;
      end
      // min and max share the greater-than bits
      alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MINU,
      alu_op_pkg::ALU_MAX, alu_op_pkg::ALU_MAXU: begin
        is_signed    = (operator_i == alu_op_pkg::ALU_MIN) ||
                       (operator_i == alu_op_pkg::ALU_MAX);
        ctrl.do_min  = (operator_i == alu_op_pkg::ALU_MIN) ||
                       (operator_i == alu_op_pkg::ALU_MINU);
        ctrl.res_sel = alu_op_pkg::RES_MINMAX;
      end
      default: ;
    endcase
  end

  // sign bit sits in the top byte of every lane
  always_comb begin
    case (vec_mode_i)
      alu_op_pkg::VEC_MODE8:  ctrl.cmp_signed = {4{is_signed}};
      alu_op_pkg::VEC_MODE16: ctrl.cmp_signed = {is_signed, 1'b0, is_signed, 1'b0};
      default:                ctrl.cmp_signed = {is_signed, 3'b000};
    endcase
  end

  always_comb begin
    assert final (!(ctrl.shift_left && ctrl.shift_arith))
      else $error("decoder asks for an arithmetic left shift");
  end

endmodule

`default_nettype wire

// File: hdl/alu_op_pkg.sv
// SIMD ALU operation encodings
// operators, vector modes and the internal datapath selects
`default_nettype none

package alu_op_pkg;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU,
    ALU_SLTS, ALU_SLTU,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU
  } alu_op_e;

  // lane split of the 32-bit word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // result mux source
  typedef enum logic [2:0] {
    RES_ADD, RES_LOGIC, RES_SHIFT, RES_VCMP, RES_SLT, RES_MINMAX
  } res_sel_e;

  typedef enum logic [1:0] { LOGIC_AND, LOGIC_OR, LOGIC_XOR } logic_op_e;

  // compare kind applied to the equal and greater bits
  typedef enum logic [1:0] { CMP_EQ, CMP_NE, CMP_LT, CMP_GE } cmp_op_e;

endpackage

`default_nettype wire

// File: hdl/alu_simd_adder.sv
// SIMD adder and subtractor
// one 36-bit adder split into byte segments by separator bits
`timescale 1ns/1ps
`default_nettype none

module alu_simd_adder (
  input  alu_data_pkg::simd_word_u operand_a_i,
  input  alu_data_pkg::simd_word_u operand_b_i,
  alu_ctrl_if.add                  ctrl,
  output alu_data_pkg::simd_word_u sum_o
);

  logic [alu_data_pkg::NUM_BYTES*alu_data_pkg::ADD_SEG_W-1:0] in_a;
  logic [alu_data_pkg::NUM_BYTES*alu_data_pkg::ADD_SEG_W-1:0] in_b;
  logic [alu_data_pkg::NUM_BYTES*alu_data_pkg::ADD_SEG_W-1:0] sum_ext;

  // separator below each byte
  //   lane start, add: 0 + 0 blocks the carry from below
  //   lane start, sub: 1 + 1 injects the +1 of the two's complement
  //   inside a lane:   1 + 0 lets the carry ripple through
  always_comb begin
    logic lane_start;
    for (int i = 0; i < alu_data_pkg::NUM_BYTES; i++) begin
      lane_start = (i == 0) || (ctrl.vec_mode == alu_op_pkg::VEC_MODE8) ||
                   ((ctrl.vec_mode == alu_op_pkg::VEC_MODE16) &&
                    (i == alu_data_pkg::NUM_BYTES / 2));
      in_a[i*alu_data_pkg::ADD_SEG_W] = lane_start ? ctrl.sub : 1'b1;
      in_b[i*alu_data_pkg::ADD_SEG_W] = lane_start ? ctrl.sub : 1'b0;
      in_a[i*alu_data_pkg::ADD_SEG_W+1 +: alu_data_pkg::BYTE_W] = operand_a_i.b[i];
      // b inverted for subtract
      in_b[i*alu_data_pkg::ADD_SEG_W+1 +: alu_data_pkg::BYTE_W] =
        operand_b_i.b[i] ^ {alu_data_pkg::BYTE_W{ctrl.sub}};
    end
  end

  // carry out of the top lane is dropped
  assign sum_ext = in_a + in_b;

  // strip the separator bits again
  always_comb begin
    for (int i = 0; i < alu_data_pkg::NUM_BYTES; i++) begin
      sum_o.b[i] = sum_ext[i*alu_data_pkg::ADD_SEG_W+1 +: alu_data_pkg::BYTE_W];
    end
  end

endmodule

`default_nettype wire

// File: hdl/alu_simd_shifter.sv
// SIMD shifter
// per-lane right shifter, left shifts run through it on bit-reversed data
`timescale 1ns/1ps
`default_nettype none

module alu_simd_shifter (
  input  alu_data_pkg::simd_word_u operand_a_i,
  input  alu_data_pkg::simd_word_u operand_b_i,
  alu_ctrl_if.shift                ctrl,
  output alu_data_pkg::simd_word_u shift_o
);

  alu_data_pkg::simd_word_u sh_in;
  alu_data_pkg::simd_word_u amt;
  alu_data_pkg::simd_word_u res_right;

  ////////////////////////////////////////////////////////////////////////////
  // operand preparation
  ////////////////////////////////////////////////////////////////////////////

  // reversing the data also reverses the lane order,
  // so the shift amounts have to follow
  always_comb begin
    if (ctrl.shift_left) begin
      sh_in = {<<{operand_a_i}};
      case (ctrl.vec_mode)
        alu_op_pkg::VEC_MODE16: amt = {<<alu_data_pkg::HALF_W{operand_b_i}};
        alu_op_pkg::VEC_MODE8:  amt = {<<alu_data_pkg::BYTE_W{operand_b_i}};
        default:                amt = operand_b_i;
      endcase
    end else begin
      sh_in = operand_a_i;
      amt   = operand_b_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // right shift per lane
  ////////////////////////////////////////////////////////////////////////////

  // one extra top bit carries the fill value for sra
  always_comb begin
    logic signed [alu_data_pkg::BYTE_W:0] tmp_b;
    logic signed [alu_data_pkg::HALF_W:0] tmp_h;
    logic signed [alu_data_pkg::XLEN:0]   tmp_w;
    tmp_b = '0;
    tmp_h = '0;
    tmp_w = '0;
    case (ctrl.vec_mode)
      alu_op_pkg::VEC_MODE16: begin
        for (int j = 0; j < 2; j++) begin
          tmp_h = $signed({ctrl.shift_arith & sh_in.h[j][alu_data_pkg::HALF_W-1],
                           sh_in.h[j]}) >>> amt.h[j][alu_data_pkg::SHAMT_W-2:0];
          res_right.h[j] = tmp_h[alu_data_pkg::HALF_W-1:0];
        end
      end
      alu_op_pkg::VEC_MODE8: begin
        for (int j = 0; j < alu_data_pkg::NUM_BYTES; j++) begin
          tmp_b = $signed({ctrl.shift_arith & sh_in.b[j][alu_data_pkg::BYTE_W-1],
                           sh_in.b[j]}) >>> amt.b[j][alu_data_pkg::SHAMT_W-3:0];
          res_right.b[j] = tmp_b[alu_data_pkg::BYTE_W-1:0];
        end
      end
      default: begin
        // 32-bit amount sits in the low bits of byte 0
        tmp_w = $signed({ctrl.shift_arith & sh_in.h[1][alu_data_pkg::HALF_W-1],
                         sh_in}) >>> amt.b[0][alu_data_pkg::SHAMT_W-1:0];
        res_right = tmp_w[alu_data_pkg::XLEN-1:0];
      end
    endcase
  end

  // undo the reversal for left shifts
  always_comb begin
    if (ctrl.shift_left) begin
      shift_o = {<<{res_right}};
    end else begin
      shift_o = res_right;
    end
  end

endmodule

`default_nettype wire

// File: hdl/simd_alu.sv
// SIMD ALU execute stage
// decoder and lane datapaths, result mux and a single output register stage
`timescale 1ns/1ps
`default_nettype none

module simd_alu (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  input  alu_op_pkg::alu_op_e           operator_i,
  input  alu_op_pkg::vec_mode_e         vec_mode_i,
  input  logic [alu_data_pkg::XLEN-1:0] operand_a_i,
  input  logic [alu_data_pkg::XLEN-1:0] operand_b_i,
  output logic                          valid_o,
  output logic [alu_data_pkg::XLEN-1:0] result_o,
  output logic                          comparison_result_o
);

  alu_data_pkg::simd_word_u           op_a;
  alu_data_pkg::simd_word_u           op_b;
  alu_data_pkg::simd_word_u           sum;
  alu_data_pkg::simd_word_u           shift_res;
  alu_data_pkg::simd_word_u           minmax;
  alu_data_pkg::simd_word_u           result_d;
  logic [alu_data_pkg::NUM_BYTES-1:0] cmp_lanes;

  alu_ctrl_if ctrl ();

  assign op_a = operand_a_i;
  assign op_b = operand_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // decoder and lane datapaths
  ////////////////////////////////////////////////////////////////////////////

  alu_decoder alu_decoder_i (
    .operator_i (operator_i),
    .vec_mode_i (vec_mode_i),
    .ctrl       (ctrl)
  );

  alu_simd_adder alu_simd_adder_i (
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .ctrl        (ctrl),
    .sum_o       (sum)
  );

  alu_simd_shifter alu_simd_shifter_i (
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .ctrl        (ctrl),
    .shift_o     (shift_res)
  );

  alu_compare alu_compare_i (
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .ctrl        (ctrl),
    .cmp_lanes_o (cmp_lanes),
    .minmax_o    (minmax)
  );

  ////////////////////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.res_sel)
      alu_op_pkg::RES_LOGIC: begin
        case (ctrl.logic_op)
          alu_op_pkg::LOGIC_OR:  result_d = operand_a_i | operand_b_i;
          alu_op_pkg::LOGIC_XOR: result_d = operand_a_i ^ operand_b_i;
          default:               result_d = operand_a_i & operand_b_i;
        endcase
      end
      alu_op_pkg::RES_SHIFT:  result_d = shift_res;
      alu_op_pkg::RES_MINMAX: result_d = minmax;
      // every byte carries its lane's mask bit
      alu_op_pkg::RES_VCMP: begin
        for (int i = 0; i < alu_data_pkg::NUM_BYTES; i++) begin
          result_d.b[i] = {alu_data_pkg::BYTE_W{cmp_lanes[i]}};
        end
      end
      alu_op_pkg::RES_SLT: result_d = {{(alu_data_pkg::XLEN-1){1'b0}}, cmp_lanes[3]};
      default:             result_d = sum;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // result and flag hold while no operation is issued
  always_ff @(posedge clk) begin
    if (valid_i) begin
      result_o            <= result_d;
      comparison_result_o <= cmp_lanes[alu_data_pkg::NUM_BYTES-1];
    end
  end

  // one-cycle latency, no stall
  assert property (@(posedge clk) disable iff (!rst_n_i)
                   $past(rst_n_i) |-> (valid_o == $past(valid_i)))
    else $error("valid_o does not follow valid_i by one cycle");

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
hdl/alu_data_pkg.sv
hdl/alu_op_pkg.sv
hdl/alu_ctrl_if.sv
hdl/alu_decoder.sv
hdl/alu_simd_adder.sv
hdl/alu_simd_shifter.sv
hdl/alu_compare.sv
hdl/simd_alu.sv
test/tb_simd_alu.sv

// File: test/alu_ref.svh
// SIMD ALU reference model
// expected result and top-lane compare flag, computed lane by lane
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

function automatic int lane_width(input alu_op_pkg::vec_mode_e mode);
  case (mode)
    alu_op_pkg::VEC_MODE8:  return alu_data_pkg::BYTE_W;
    alu_op_pkg::VEC_MODE16: return alu_data_pkg::HALF_W;
    default:                return alu_data_pkg::XLEN;
  endcase
endfunction

// unsigned value of lane l, read through the byte or halfword view
function automatic longint lane_value(input alu_data_pkg::simd_word_u w,
                                      input alu_op_pkg::vec_mode_e mode, input int l);
  case (mode)
    alu_op_pkg::VEC_MODE8:  return longint'(w.b[l]);
    alu_op_pkg::VEC_MODE16: return longint'(w.h[l]);
    default:                return longint'(w.b);
  endcase
endfunction

// returns {flag, result}
function automatic logic [alu_data_pkg::XLEN:0] alu_ref(
    input alu_op_pkg::alu_op_e op, input alu_op_pkg::vec_mode_e mode,
    input logic [alu_data_pkg::XLEN-1:0] a, input logic [alu_data_pkg::XLEN-1:0] b);
  alu_data_pkg::simd_word_u wa;
  alu_data_pkg::simd_word_u wb;
  int     w;
  int     amt;
  longint mask;
  longint half;
  longint la;
  longint lb;
  longint sa;
  longint sb;
  longint lr;
  longint res;
  logic   is_s;
  logic   lt;
  logic   eq;
  logic   cmp;
  logic   flag;
  wa   = a;
  wb   = b;
  w    = lane_width(mode);
  mask = (longint'(1) << w) - 1;
  half = longint'(1) << (w - 1);
  res  = 0;
  flag = 1'b0;
  is_s = op inside {alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_GES, alu_op_pkg::ALU_SLTS,
                    alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MAX};
  for (int l = 0; l < alu_data_pkg::XLEN / w; l++) begin
    la  = lane_value(wa, mode, l);
    lb  = lane_value(wb, mode, l);
    // two's complement view of the lane
    sa  = (la ^ half) - half;
    sb  = (lb ^ half) - half;
    eq  = (la == lb);
    lt  = is_s ? (sa < sb) : (la < lb);
    // only the low log2(width) bits of the amount count
    amt = int'(lb % w);
    cmp = 1'b0;
    lr  = 0;
    case (op)
      alu_op_pkg::ALU_ADD:  lr = la + lb;
      alu_op_pkg::ALU_SUB:  lr = la - lb;
      alu_op_pkg::ALU_AND:  lr = la & lb;
      alu_op_pkg::ALU_OR:   lr = la | lb;
      alu_op_pkg::ALU_XOR:  lr = la ^ lb;
      alu_op_pkg::ALU_SLL:  lr = la << amt;
      alu_op_pkg::ALU_SRL:  lr = la >> amt;
      alu_op_pkg::ALU_SRA:  lr = sa >>> amt;
      alu_op_pkg::ALU_EQ:   cmp = eq;
      alu_op_pkg::ALU_NE:   cmp = !eq;
      alu_op_pkg::ALU_LTS, alu_op_pkg::ALU_LTU, alu_op_pkg::ALU_SLTS,
      alu_op_pkg::ALU_SLTU: cmp = lt;
      alu_op_pkg::ALU_GES, alu_op_pkg::ALU_GEU: cmp = !lt;
      alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MINU: lr = lt ? la : lb;
      default:              lr = lt ? lb : la;
    endcase
    // vector compares fill the whole lane
    if (op inside {[alu_op_pkg::ALU_EQ:alu_op_pkg::ALU_GEU]}) begin
      lr = cmp ? mask : 0;
    end
    res  = res | ((lr & mask) << (l * w));
    flag = cmp;
  end
  // set-less-than keeps only the top-lane outcome in bit 0
  if (op inside {alu_op_pkg::ALU_SLTS, alu_op_pkg::ALU_SLTU}) begin
    res = longint'(flag);
  end
  return {flag, res[alu_data_pkg::XLEN-1:0]};
endfunction

`endif

// File: test/tb_simd_alu.sv
// SIMD ALU testbench
// random operations per operator and mode, checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_simd_alu;

  `include "alu_ref.svh"

  logic                          clk;
  logic                          rst_n_i;
  logic                          valid_i;
  alu_op_pkg::alu_op_e           operator_i;
  alu_op_pkg::vec_mode_e         vec_mode_i;
  logic [alu_data_pkg::XLEN-1:0] operand_a_i;
  logic [alu_data_pkg::XLEN-1:0] operand_b_i;
  logic                          valid_o;
  logic [alu_data_pkg::XLEN-1:0] result_o;
  logic                          comparison_result_o;

  // expected values for operations in flight, oldest first
  logic [alu_data_pkg::XLEN:0] exp_q[$];
  bit                          flag_chk_q[$];
  int                          due_q[$];
  string                       name_q[$];
  int                          cyc;
  int                          errors;
  int                          checks;

  simd_alu simd_alu_i (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .valid_i             (valid_i),
    .operator_i          (operator_i),
    .vec_mode_i          (vec_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .valid_o             (valid_o),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic alu_op_pkg::vec_mode_e mode_sel(input int m);
    case (m)
      0:       return alu_op_pkg::VEC_MODE32;
      1:       return alu_op_pkg::VEC_MODE16;
      default: return alu_op_pkg::VEC_MODE8;
    endcase
  endfunction

  // random word with some bytes forced to edge values
  function automatic logic [alu_data_pkg::XLEN-1:0] rand_operand();
    logic [alu_data_pkg::XLEN-1:0] v;
    v = $urandom;
    for (int i = 0; i < alu_data_pkg::NUM_BYTES; i++) begin
      case ($urandom_range(7, 0))
        0:       v[i*8 +: 8] = 8'hff;
        1:       v[i*8 +: 8] = 8'h00;
        2:       v[i*8 +: 8] = 8'h80;
        3:       v[i*8 +: 8] = 8'h7f;
        default: ;
      endcase
    end
    return v;
  endfunction

  // equal to a or off by one byte half the time, so eq lanes get hit
  function automatic logic [alu_data_pkg::XLEN-1:0] near_operand(
      input logic [alu_data_pkg::XLEN-1:0] a);
    case ($urandom_range(3, 0))
      0:       return a;
      1:       return a ^ (32'h0000_00ff << (8 * $urandom_range(3, 0)));
      default: return rand_operand();
    endcase
  endfunction

  task automatic issue_op(input alu_op_pkg::alu_op_e op, input alu_op_pkg::vec_mode_e mode,
                          input logic [alu_data_pkg::XLEN-1:0] a,
                          input logic [alu_data_pkg::XLEN-1:0] b);
    @(posedge clk);
    valid_i     <= 1'b1;
    operator_i  <= op;
    vec_mode_i  <= mode;
    operand_a_i <= a;
    operand_b_i <= b;
    exp_q.push_back(alu_ref(op, mode, a, b));
    flag_chk_q.push_back(op inside {[alu_op_pkg::ALU_EQ:alu_op_pkg::ALU_SLTU]});
    // driven at edge N, registered at N+1, seen by the checker at N+2
    due_q.push_back(cyc + 2);
    name_q.push_back($sformatf("%s/%s", op.name(), mode.name()));
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      valid_i <= 1'b0;
    end
  endtask

  // every operator in [first, last] in all three modes
  task automatic run_ops(input alu_op_pkg::alu_op_e first, input alu_op_pkg::alu_op_e last,
                         input int per_mode);
    logic [alu_data_pkg::XLEN-1:0] a;
    for (int k = int'(first); k <= int'(last); k++) begin
      for (int m = 0; m < 3; m++) begin
        for (int r = 0; r < per_mode; r++) begin
          a = rand_operand();
          issue_op(alu_op_pkg::alu_op_e'(5'(k)), mode_sel(m), a, near_operand(a));
        end
      end
    end
    idle(2);
  endtask

  task automatic issue_random();
    logic [alu_data_pkg::XLEN-1:0] a;
    a = rand_operand();
    issue_op(alu_op_pkg::alu_op_e'(5'($urandom_range(19, 0))),
             mode_sel(int'($urandom_range(2, 0))), a, near_operand(a));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR: timeout, %0d results never came back", exp_q.size());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // result checker
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : check_results
    logic [alu_data_pkg::XLEN:0] exp;
    bit                          chk_flag;
    int                          due;
    string                       name;
    if (rst_n_i === 1'b1 && $isunknown(valid_o)) begin
      errors++;
      $display("ERROR: valid_o is unknown after reset");
    end
    if (valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: result appeared with no operation in flight");
      end else begin
        exp      = exp_q.pop_front();
        chk_flag = flag_chk_q.pop_front();
        due      = due_q.pop_front();
        name     = name_q.pop_front();
        checks++;
        if (result_o !== exp[alu_data_pkg::XLEN-1:0]) begin
          errors++;
          $display("CHECK FAILED %s: expected %h, actual %h",
                   name, exp[alu_data_pkg::XLEN-1:0], result_o);
        end
        // flag only carries meaning for compares
        if (chk_flag && comparison_result_o !== exp[alu_data_pkg::XLEN]) begin
          errors++;
          $display("CHECK FAILED %s flag: expected %b, actual %b",
                   name, exp[alu_data_pkg::XLEN], comparison_result_o);
        end
        if (cyc != due) begin
          errors++;
          $display("ERROR: %s result came at cycle %0d instead of %0d", name, cyc, due);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    operator_i  = alu_op_pkg::ALU_ADD;
    vec_mode_i  = alu_op_pkg::VEC_MODE32;
    operand_a_i = '0;
    operand_b_i = '0;
    cyc         = 0;
    errors      = 0;
    checks      = 0;
    void'($urandom(15));

    // issue during reset up to its last edge, none of it may come out
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      valid_i     <= (i >= 4);
      operand_a_i <= rand_operand();
      if (i > 0 && valid_o !== 1'b0) begin
        errors++;
        $display("ERROR: valid_o not low during reset");
      end
    end
    @(posedge clk);
    rst_n_i <= 1'b1;
    valid_i <= 1'b0;
    // last reset edge saw valid_i high, output must still be low
    @(posedge clk);
    if (valid_o !== 1'b0) begin
      errors++;
      $display("ERROR: valid_o high in the first cycle after reset");
    end

    run_ops(alu_op_pkg::ALU_ADD, alu_op_pkg::ALU_SUB, 16);
    run_ops(alu_op_pkg::ALU_AND, alu_op_pkg::ALU_XOR, 8);
    run_ops(alu_op_pkg::ALU_SLL, alu_op_pkg::ALU_SRA, 16);
    run_ops(alu_op_pkg::ALU_EQ, alu_op_pkg::ALU_SLTU, 12);
    run_ops(alu_op_pkg::ALU_MIN, alu_op_pkg::ALU_MAXU, 12);

    // back to back, then with idle gaps
    for (int i = 0; i < 200; i++) begin
      issue_random();
    end
    for (int i = 0; i < 60; i++) begin
      if ($urandom_range(2, 0) == 0) begin
        idle(int'($urandom_range(3, 1)));
      end else begin
        issue_random();
      end
    end
    idle(1);
    drain();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
